// ==== design/apb_reg_port.sv ====
`timescale 1ns/1ns
`include "seq_defs.svh"

module apb_reg_port (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [`SEQ_APB_ADDR_W-1:0]  paddr,
    input  logic [`SEQ_APB_DATA_W-1:0]  pwdata,
    output logic [`SEQ_APB_DATA_W-1:0]  prdata,
    output logic                        pready,
    output logic                        pslverr,
    input  seq_pkg::run_state_t         run_state,
    input  seq_pkg::slot_cnt_t          main_cnt,
    input  seq_pkg::slot_cnt_t          end_cnt,
    input  logic [`SEQ_APB_DATA_W-1:0]  host_rdata,
    output logic                        ctrl_wr,
    output seq_pkg::ctrl_cmd_t          ctrl_cmd,
    output logic                        end_cnt_wr,
    output seq_pkg::slot_cnt_t          end_cnt_wdata,
    output logic                        slot_wr,
    output slot_pkg::slot_idx_t         slot_idx,
    output slot_pkg::slot_field_t       slot_field,
    output logic [`SEQ_APB_DATA_W-1:0]  slot_wdata
);
    import seq_pkg::*;
    import slot_pkg::*;

    localparam int DW        = `SEQ_APB_DATA_W;
    localparam int STRIDE_SH = $clog2(`SEQ_SLOT_STRIDE);           // slot index position
    localparam int SLOT_SPAN = `SEQ_SLOT_STRIDE << `SEQ_SLOT_IDX_W; // bytes of the slot bank
    localparam int FLD_W     = $bits(slot_field_t);

    logic                       access;     // apb access phase
    logic                       aligned;
    logic [`SEQ_APB_ADDR_W-1:0] slot_off;   // offset into the slot bank
    logic                       hit_ctrl;
    logic                       hit_state;
    logic                       hit_main;
    logic                       hit_end;
    logic                       hit_slot;
    logic                       fld_ok;
    logic                       mapped;
    logic                       idle;       // table and end count open to the host
    logic                       err;
    logic                       wr_ok;
    ctrl_cmd_t                  ctrl_last;  // last command code written
    logic [DW-1:0]              rdata;

    ////////////////////
    // address decode
    assign access    = psel && penable;
    assign aligned   = (paddr[1:0] == 2'b00);
    assign slot_off  = paddr - `SEQ_SLOT_BASE;
    assign hit_ctrl  = aligned && (paddr == `SEQ_REG_CTRL);
    assign hit_state = aligned && (paddr == `SEQ_REG_STATE);
    assign hit_main  = aligned && (paddr == `SEQ_REG_MAIN_CNT);
    assign hit_end   = aligned && (paddr == `SEQ_REG_END_CNT);
    assign hit_slot  = aligned && (paddr >= `SEQ_SLOT_BASE) && (slot_off < SLOT_SPAN);

    assign slot_idx   = slot_off[STRIDE_SH +: `SEQ_SLOT_IDX_W];
    assign slot_field = slot_field_t'(slot_off[2 +: FLD_W]);
    assign fld_ok     = (slot_field <= fld_profile);   // offsets 6, 7 fall through

    assign mapped = hit_ctrl || hit_state || hit_main || hit_end || (hit_slot && fld_ok);
    assign idle   = (run_state == st_shutdown);

    ////////////////////
    // access validation
    // the shutdown-only rule lives here and nowhere else
    assign err = !mapped
              || (pwrite && (hit_state || hit_main))   // read-only registers
              || ((hit_end || hit_slot) && !idle);

    assign pready  = 1'b1;                 // zero wait states
    assign pslverr = access && err;
    assign wr_ok   = access && pwrite && !err;

    // single-cycle strobes, already validated
    assign ctrl_wr       = wr_ok && hit_ctrl;
    assign end_cnt_wr    = wr_ok && hit_end;
    assign slot_wr       = wr_ok && hit_slot;
    assign ctrl_cmd      = ctrl_cmd_t'(pwdata[$bits(ctrl_cmd_t)-1:0]);
    assign end_cnt_wdata = pwdata[`SEQ_SLOT_IDX_W-1:0];   // low bits only
    assign slot_wdata    = pwdata;                         // slot_table trims per field

    // control register reads back what the host wrote
    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl_last <= cmd_clear;
        end else if (ctrl_wr) begin
            ctrl_last <= ctrl_cmd;
        end
    end

    ////////////////////
    // read mux
    always_comb begin
        rdata = '0;
        if (hit_ctrl)
            rdata = DW'(ctrl_last);
        else if (hit_state)
            rdata = DW'(run_state);
        else if (hit_main)
            rdata = DW'(main_cnt);
        else if (hit_end)
            rdata = DW'(end_cnt);
        else if (hit_slot)
            rdata = host_rdata;         // already zero-extended
    end

    assign prdata = (access && !pwrite && !err) ? rdata : '0;

    // no write may reach the core on an access that was refused
    a_no_wr_on_err: assert property (@(posedge clk) disable iff (reset)
        (ctrl_wr || end_cnt_wr || slot_wr) |-> !pslverr)
        else $error("write strobe together with pslverr");

endmodule

// ==== design/seq_defs.svh ====
`ifndef SEQ_DEFS_SVH
`define SEQ_DEFS_SVH

////////////////////
// slot table geometry
`define SEQ_SLOT_IDX_W      2       // 2 ^ 2 = 4 slots
`define SEQ_ADDR_W          32      // source / destination address
`define SEQ_SIZE_W          26      // source / destination size
`define SEQ_SLOT_STATUS_W   2
`define SEQ_PROFILE_W       32      // reprogram count per slot

////////////////////
// apb port
`define SEQ_APB_ADDR_W      8
`define SEQ_APB_DATA_W      32

// control bank
`define SEQ_REG_CTRL        8'h00   // command, last code reads back
`define SEQ_REG_STATE       8'h04   // run state, read only
`define SEQ_REG_MAIN_CNT    8'h08   // main counter, read only
`define SEQ_REG_END_CNT     8'h0C   // last slot of a run

// slot bank
// slot n field f sits at base + n * stride + f * 4
`define SEQ_SLOT_BASE       8'h40
`define SEQ_SLOT_STRIDE     8'h20

`endif

// ==== design/seq_fsm.sv ====
`timescale 1ns/1ns

module seq_fsm (
    input  logic                clk,
    input  logic                reset,
    input  logic                ctrl_wr,
    input  seq_pkg::ctrl_cmd_t  ctrl_cmd,
    input  logic                end_cnt_wr,
    input  seq_pkg::slot_cnt_t  end_cnt_wdata,
    output seq_pkg::run_state_t run_state,
    output seq_pkg::slot_cnt_t  main_cnt,
    output seq_pkg::slot_cnt_t  end_cnt,
    output logic                profile_inc,
    output logic                reprog,
    output logic                init,
    output logic                start_exec,
    input  logic                reprog_accept,
    input  logic                init_done,
    input  logic                start_accept,
    input  logic                exec_done
);
    import seq_pkg::*;

    run_state_t state_nxt;
    slot_cnt_t  cnt_nxt;
    logic       ctrl_take;   // command overrides the handshake this cycle

    // start is only honoured from shutdown, unknown codes are dropped
    assign ctrl_take = ctrl_wr && ((ctrl_cmd == cmd_clear)
                                || (ctrl_cmd == cmd_shutdown)
                                || ((ctrl_cmd == cmd_start) && (run_state == st_shutdown)));

    ////////////////////
    // next state
    always_comb begin
        state_nxt = run_state;
        cnt_nxt   = main_cnt;
        if (ctrl_take) begin
            case (ctrl_cmd)
                cmd_clear: begin
                    state_nxt = st_shutdown;
                    cnt_nxt   = '0;
                end
                cmd_shutdown: state_nxt = st_shutdown;   // counter kept for the host
                default: begin                           // start
                    state_nxt = st_reprog;
                    cnt_nxt   = '0;
                end
            endcase
        end else begin
            case (run_state)
                st_shutdown: ;
                st_reprog:   if (reprog_accept) state_nxt = st_init;
                st_init:     if (init_done)     state_nxt = st_trigger;
                st_trigger:  if (start_accept)  state_nxt = st_wait_fin;
                st_wait_fin: begin
                    if (exec_done) begin
                        if (main_cnt < end_cnt) begin
                            cnt_nxt   = main_cnt + slot_cnt_t'(1);  // next slot
                            state_nxt = st_reprog;
                        end else begin
                            cnt_nxt   = '0;                         // run complete
                            state_nxt = st_shutdown;
                        end
                    end
                end
                default: state_nxt = st_shutdown;   // unused codes recover
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            run_state <= st_shutdown;
            main_cnt  <= '0;
        end else begin
            run_state <= state_nxt;
            main_cnt  <= cnt_nxt;
        end
    end

    // end count has a single owner
    always_ff @(posedge clk) begin
        if (reset)
            end_cnt <= '0;
        else if (end_cnt_wr)
            end_cnt <= end_cnt_wdata;
    end

    ////////////////////
    // slave dma handshake
    assign reprog      = (run_state == st_reprog);
    assign init        = (run_state == st_init);
    assign start_exec  = (run_state == st_trigger);
    assign profile_inc = reprog && reprog_accept && !ctrl_take;   // one per accepted reprog

    // holds only while the port keeps end count writes out of a run
    a_cnt_in_range: assert property (@(posedge clk) disable iff (reset)
        (run_state != st_shutdown) |-> (main_cnt <= end_cnt))
        else $error("main_cnt beyond end_cnt while running");

endmodule

// ==== design/seq_pkg.sv ====
`include "seq_defs.svh"

package seq_pkg;

    // sequencer run state, as seen in the state register
    typedef enum logic [2:0] {
        st_shutdown = 3'd0,   // idle, host owns the table
        st_reprog   = 3'd1,   // slave told to reprogram
        st_init     = 3'd2,
        st_trigger  = 3'd3,   // start_exec raised
        st_wait_fin = 3'd4    // waiting on exec_done
    } run_state_t;

    // host commands written to the control register
    typedef enum logic [3:0] {
        cmd_clear    = 4'd0,  // stop and zero the main counter
        cmd_shutdown = 4'd1,  // stop, counter kept
        cmd_start    = 4'd2
    } ctrl_cmd_t;

    // main and end counter
    typedef logic [`SEQ_SLOT_IDX_W-1:0] slot_cnt_t;

endpackage

// ==== design/seq_top.sv ====
`timescale 1ns/1ns
`include "seq_defs.svh"

module seq_top (
    input  logic                        clk,
    input  logic                        reset,
    // apb slave
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [`SEQ_APB_ADDR_W-1:0]  paddr,
    input  logic [`SEQ_APB_DATA_W-1:0]  pwdata,
    output logic [`SEQ_APB_DATA_W-1:0]  prdata,
    output logic                        pready,
    output logic                        pslverr,
    // slave dma handshake
    output logic                        reprog,
    output logic                        init,
    output logic                        start_exec,
    input  logic                        reprog_accept,
    input  logic                        init_done,
    input  logic                        start_accept,
    input  logic                        exec_done,
    // current slot to the slave dma
    output slot_pkg::dma_addr_t         dma_src_addr,
    output slot_pkg::dma_size_t         dma_src_size,
    output slot_pkg::dma_addr_t         dma_dst_addr,
    output slot_pkg::dma_size_t         dma_dst_size,
    output slot_pkg::slot_status_t      dma_slot_status,
    output slot_pkg::profile_t          dma_profile
);
    import seq_pkg::*;
    import slot_pkg::*;

    run_state_t                 run_state;
    slot_cnt_t                  main_cnt;
    slot_cnt_t                  end_cnt;
    logic                       ctrl_wr;
    ctrl_cmd_t                  ctrl_cmd;
    logic                       end_cnt_wr;
    slot_cnt_t                  end_cnt_wdata;
    logic                       slot_wr;
    slot_idx_t                  slot_idx;
    slot_field_t                slot_field;
    logic [`SEQ_APB_DATA_W-1:0] slot_wdata;
    logic [`SEQ_APB_DATA_W-1:0] host_rdata;
    logic                       profile_inc;

    ////////////////////
    apb_reg_port reg_port_i (
        .clk, .reset,
        .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr,
        .run_state, .main_cnt, .end_cnt, .host_rdata,
        .ctrl_wr, .ctrl_cmd, .end_cnt_wr, .end_cnt_wdata,
        .slot_wr, .slot_idx, .slot_field, .slot_wdata
    );

    seq_fsm fsm_i (
        .clk, .reset,
        .ctrl_wr, .ctrl_cmd, .end_cnt_wr, .end_cnt_wdata,
        .run_state, .main_cnt, .end_cnt, .profile_inc,
        .reprog, .init, .start_exec,
        .reprog_accept, .init_done, .start_accept, .exec_done
    );

    slot_table table_i (
        .clk, .reset,
        .slot_wr, .slot_idx, .slot_field, .slot_wdata,
        .profile_inc, .main_cnt,              // increment targets the running slot
        .host_rdata,
        .dma_src_addr, .dma_src_size, .dma_dst_addr, .dma_dst_size,
        .dma_slot_status, .dma_profile
    );

endmodule

// ==== design/slot_pkg.sv ====
`include "seq_defs.svh"

package slot_pkg;

    typedef logic [`SEQ_SLOT_IDX_W-1:0]    slot_idx_t;    // which slot
    typedef logic [`SEQ_ADDR_W-1:0]        dma_addr_t;    // src or dst address
    typedef logic [`SEQ_SIZE_W-1:0]        dma_size_t;    // src or dst size
    typedef logic [`SEQ_SLOT_STATUS_W-1:0] slot_status_t;
    typedef logic [`SEQ_PROFILE_W-1:0]     profile_t;     // accepted reprograms

    ////////////////////
    // field number inside a slot, times 4 gives the byte offset
    typedef enum logic [2:0] {
        fld_src_addr = 3'd0,
        fld_src_size = 3'd1,
        fld_dst_addr = 3'd2,
        fld_dst_size = 3'd3,
        fld_status   = 3'd4,
        fld_profile  = 3'd5
        // 6 and 7 are holes in the map
    } slot_field_t;

endpackage

// ==== design/slot_table.sv ====
`timescale 1ns/1ns
`include "seq_defs.svh"

module slot_table (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        slot_wr,
    input  slot_pkg::slot_idx_t         slot_idx,
    input  slot_pkg::slot_field_t       slot_field,
    input  logic [`SEQ_APB_DATA_W-1:0]  slot_wdata,
    input  logic                        profile_inc,
    input  seq_pkg::slot_cnt_t          main_cnt,
    output logic [`SEQ_APB_DATA_W-1:0]  host_rdata,
    output slot_pkg::dma_addr_t         dma_src_addr,
    output slot_pkg::dma_size_t         dma_src_size,
    output slot_pkg::dma_addr_t         dma_dst_addr,
    output slot_pkg::dma_size_t         dma_dst_size,
    output slot_pkg::slot_status_t      dma_slot_status,
    output slot_pkg::profile_t          dma_profile
);
    import slot_pkg::*;

    localparam int NUM_SLOTS = 1 << `SEQ_SLOT_IDX_W;
    localparam int DW        = `SEQ_APB_DATA_W;

    // one array per field, indexed by slot
    dma_addr_t    src_addr [NUM_SLOTS];
    dma_size_t    src_size [NUM_SLOTS];
    dma_addr_t    dst_addr [NUM_SLOTS];
    dma_size_t    dst_size [NUM_SLOTS];
    slot_status_t status   [NUM_SLOTS];
    profile_t     profile  [NUM_SLOTS];

    ////////////////////
    // host write and profile count
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin   // table comes up zero
                src_addr[i] <= '0;
                src_size[i] <= '0;
                dst_addr[i] <= '0;
                dst_size[i] <= '0;
                status[i]   <= '0;
                profile[i]  <= '0;
            end
        end else if (slot_wr) begin
            case (slot_field)
                fld_src_addr: src_addr[slot_idx] <= slot_wdata[`SEQ_ADDR_W-1:0];
                fld_src_size: src_size[slot_idx] <= slot_wdata[`SEQ_SIZE_W-1:0];
                fld_dst_addr: dst_addr[slot_idx] <= slot_wdata[`SEQ_ADDR_W-1:0];
                fld_dst_size: dst_size[slot_idx] <= slot_wdata[`SEQ_SIZE_W-1:0];
                fld_status:   status[slot_idx]   <= slot_wdata[`SEQ_SLOT_STATUS_W-1:0];
                fld_profile:  profile[slot_idx]  <= slot_wdata[`SEQ_PROFILE_W-1:0];
                default: ;                        // holes, refused upstream
            endcase
        end else if (profile_inc) begin
            profile[main_cnt] <= profile[main_cnt] + profile_t'(1);  // one per accepted reprog
        end
    end

    ////////////////////
    // host read port, zero-extended to the bus
    always_comb begin
        case (slot_field)
            fld_src_addr: host_rdata = DW'(src_addr[slot_idx]);
            fld_src_size: host_rdata = DW'(src_size[slot_idx]);
            fld_dst_addr: host_rdata = DW'(dst_addr[slot_idx]);
            fld_dst_size: host_rdata = DW'(dst_size[slot_idx]);
            fld_status:   host_rdata = DW'(status[slot_idx]);
            fld_profile:  host_rdata = DW'(profile[slot_idx]);
            default:      host_rdata = '0;
        endcase
    end

    // dispatch port follows the main counter
    assign dma_src_addr    = src_addr[main_cnt];
    assign dma_src_size    = src_size[main_cnt];
    assign dma_dst_addr    = dst_addr[main_cnt];
    assign dma_dst_size    = dst_size[main_cnt];
    assign dma_slot_status = status[main_cnt];
    assign dma_profile     = profile[main_cnt];

    // host writes only in shutdown, increments only in st_reprog
    a_wr_inc_excl: assert property (@(posedge clk) disable iff (reset)
        !(slot_wr && profile_inc))
        else $error("host slot write collides with profile increment");

endmodule

// ==== sim/seq_tb.sv ====
`timescale 1ns/1ns
`include "seq_defs.svh"

module seq_tb;

    localparam logic [31:0] SEED = 32'hd5e6_92d2;
    localparam int NUM_RUNS    = 6;                         // full runs, abort run extra
    localparam int NUM_ACCESS  = 400;                       // apb accesses outside runs
    localparam int WATCHDOG_NS = ((NUM_RUNS + 1) * 4 * 40 + NUM_ACCESS * 4) * 20;
    localparam logic [2:0] ST_SHUT   = 3'd0;
    localparam logic [2:0] ST_REPROG = 3'd1;
    localparam logic [2:0] ST_INIT   = 3'd2;
    localparam logic [2:0] ST_TRIG   = 3'd3;
    localparam logic [2:0] ST_WAIT   = 3'd4;

    logic        clk, reset;
    logic        psel, penable, pwrite, pready, pslverr;
    logic [7:0]  paddr;
    logic [31:0] pwdata, prdata;
    logic        reprog, init, start_exec;
    logic        reprog_accept, init_done, start_accept, exec_done;
    logic [31:0] dma_src_addr, dma_dst_addr, dma_profile;
    logic [25:0] dma_src_size, dma_dst_size;
    logic [1:0]  dma_slot_status;

    // reference model of the sequencer
    logic [31:0] m_fld [4][6];      // slot, field
    logic [1:0]  m_end;
    logic [1:0]  m_main;
    logic [3:0]  m_ctrl;
    logic [2:0]  m_state;
    int          seed;
    int          errors;
    int          checks;
    logic [7:0]  bad_addr [4] = '{8'h10, 8'h58, 8'hc0, 8'h41};   // hole, field 6, past, odd

    seq_top dut_i (.*);
    slave_dma_bfm #(.SEED(SEED)) bfm_i (.*);

    always #10 clk = ~clk;

    ////////////////////
    // model helpers
    function automatic logic [31:0] field_mask(input logic [2:0] f);
        case (f)
            3'd1, 3'd3: return (32'd1 << `SEQ_SIZE_W) - 1;
            3'd4:       return (32'd1 << `SEQ_SLOT_STATUS_W) - 1;
            default:    return 32'hffff_ffff;
        endcase
    endfunction

    function automatic logic slot_hit(input logic [7:0] addr);
        logic [7:0] off;
        off = addr - `SEQ_SLOT_BASE;
        return (addr[1:0] == 2'b00) && (addr >= `SEQ_SLOT_BASE)
            && (off < 4 * `SEQ_SLOT_STRIDE) && (off[4:2] <= 3'd5);
    endfunction

    function automatic logic predict_err(input logic wr, input logic [7:0] addr);
        logic hit_open;     // end count or slot field
        hit_open = (addr == `SEQ_REG_END_CNT) || slot_hit(addr);
        if (wr && ((addr == `SEQ_REG_STATE) || (addr == `SEQ_REG_MAIN_CNT)))
            return 1'b1;
        if (hit_open && (m_state != ST_SHUT))
            return 1'b1;
        return !(hit_open || (addr == `SEQ_REG_CTRL) || (addr == `SEQ_REG_STATE)
              || (addr == `SEQ_REG_MAIN_CNT));
    endfunction

    function automatic logic [31:0] model_rdata(input logic [7:0] addr);
        logic [7:0] off;
        off = addr - `SEQ_SLOT_BASE;
        case (addr)
            `SEQ_REG_CTRL:     return 32'(m_ctrl);
            `SEQ_REG_STATE:    return 32'(m_state);
            `SEQ_REG_MAIN_CNT: return 32'(m_main);
            `SEQ_REG_END_CNT:  return 32'(m_end);
            default:           return slot_hit(addr) ? m_fld[off[6:5]][off[4:2]] : 32'h0;
        endcase
    endfunction

    function automatic logic [7:0] slot_addr(input int s, input int f);
        return 8'(`SEQ_SLOT_BASE + s * `SEQ_SLOT_STRIDE + f * 4);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    ////////////////////
    // apb host, starts and ends 2 ns after a rising edge
    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata);
        logic        exp_err;
        logic [31:0] exp_rd;
        logic [7:0]  off;
        psel    = 1'b1;                     // setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #2;
        penable = 1'b1;                     // access phase
        exp_err = predict_err(wr, addr);
        exp_rd  = model_rdata(addr);
        #6;
        rdata = prdata;
        check_value("pready", pready, 1'b1);
        check_value("pslverr", pslverr, exp_err);
        if (!wr && !exp_err)
            check_value($sformatf("prdata[%h]", addr), prdata, exp_rd);
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        if (wr && !exp_err) begin           // mirror the accepted write
            off = addr - `SEQ_SLOT_BASE;
            if (addr == `SEQ_REG_CTRL)
                m_ctrl = wdata[3:0];
            else if (addr == `SEQ_REG_END_CNT)
                m_end = wdata[1:0];
            else
                m_fld[off[6:5]][off[4:2]] = wdata & field_mask(off[4:2]);
        end
    endtask

    task automatic compare_all_regs();
        logic [31:0] rd;
        apb_access(1'b0, `SEQ_REG_CTRL, 32'h0, rd);
        apb_access(1'b0, `SEQ_REG_STATE, 32'h0, rd);
        apb_access(1'b0, `SEQ_REG_MAIN_CNT, 32'h0, rd);
        apb_access(1'b0, `SEQ_REG_END_CNT, 32'h0, rd);
        for (int s = 0; s < 4; s++)
            for (int f = 0; f < 6; f++)
                apb_access(1'b0, slot_addr(s, f), 32'h0, rd);
    endtask

    // access that a running sequencer must refuse
    task automatic probe_during_run();
        logic [31:0] rd;
        int          s;
        int          f;
        s = $unsigned($random(seed)) % 4;
        f = $unsigned($random(seed)) % 6;
        case ($unsigned($random(seed)) % 5)
            0:       apb_access(1'b1, slot_addr(s, f), $random(seed), rd);
            1:       apb_access($random(seed) & 1, `SEQ_REG_END_CNT, $random(seed), rd);
            2:       apb_access(1'b0, slot_addr(s, f), 32'h0, rd);
            3:       apb_access($random(seed) & 1, bad_addr[s], $random(seed), rd);
            default: apb_access(1'b1, `SEQ_REG_STATE, $random(seed), rd);
        endcase
    endtask

    ////////////////////
    // cycle model, inputs are stable at the falling edge
    always @(negedge clk) begin
        logic [3:0] cmd;
        logic       cmd_take;   // command honoured this cycle
        if (!reset) begin
            check_value("reprog", reprog, m_state == ST_REPROG);
            check_value("init", init, m_state == ST_INIT);
            check_value("start_exec", start_exec, m_state == ST_TRIG);
            if (m_state == ST_TRIG) begin   // slot presented to the slave
                check_value("dma_src_addr", dma_src_addr, m_fld[m_main][0]);
                check_value("dma_src_size", dma_src_size, m_fld[m_main][1]);
                check_value("dma_dst_addr", dma_dst_addr, m_fld[m_main][2]);
                check_value("dma_dst_size", dma_dst_size, m_fld[m_main][3]);
                check_value("dma_slot_status", dma_slot_status, m_fld[m_main][4]);
                check_value("dma_profile", dma_profile, m_fld[m_main][5]);
            end
            cmd      = pwdata[3:0];
            cmd_take = psel && penable && pwrite && (paddr == `SEQ_REG_CTRL)
                    && ((cmd == 4'd0) || (cmd == 4'd1)
                     || ((cmd == 4'd2) && (m_state == ST_SHUT)));   // start only from shutdown
            if (cmd_take) begin   // command wins
                if (cmd == 4'd0) begin
                    m_state = ST_SHUT;
                    m_main  = 2'd0;
                end else if (cmd == 4'd1) begin
                    m_state = ST_SHUT;
                end else begin
                    m_state = ST_REPROG;
                    m_main  = 2'd0;
                end
            end else if ((m_state == ST_REPROG) && reprog_accept) begin
                m_fld[m_main][5] = m_fld[m_main][5] + 1;
                m_state = ST_INIT;
            end else if ((m_state == ST_INIT) && init_done) begin
                m_state = ST_TRIG;
            end else if ((m_state == ST_TRIG) && start_accept) begin
                m_state = ST_WAIT;
            end else if ((m_state == ST_WAIT) && exec_done) begin
                m_state = (m_main < m_end) ? ST_REPROG : ST_SHUT;
                m_main  = (m_main < m_end) ? m_main + 2'd1 : 2'd0;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout, sequencer still busy after %0d ns with %0d errors", WATCHDOG_NS,
                 errors);
        $display("test failed");
        $finish;
    end

    ////////////////////
    // test sequence
    initial begin
        logic [31:0] rd;
        logic [3:0]  code;
        clk     = 1'b0;
        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = 8'h0;
        pwdata  = 32'h0;
        seed    = SEED;
        errors  = 0;
        checks  = 0;
        m_fld   = '{default: '{default: 32'h0}};   // table resets to zero
        m_end   = 2'd0;
        m_main  = 2'd0;
        m_ctrl  = 4'd0;
        m_state = ST_SHUT;
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;

        // program everything in shutdown and read it back
        for (int s = 0; s < 4; s++)
            for (int f = 0; f < 6; f++)
                apb_access(1'b1, slot_addr(s, f), $random(seed), rd);
        apb_access(1'b1, `SEQ_REG_END_CNT, $random(seed), rd);
        code = $random(seed);
        if (code == 4'd2)
            code = 4'd1;                    // start would leave shutdown
        apb_access(1'b1, `SEQ_REG_CTRL, 32'(code), rd);
        compare_all_regs();

        // full runs with refused accesses in between
        for (int r = 0; r < NUM_RUNS; r++) begin
            apb_access(1'b1, `SEQ_REG_END_CNT, $random(seed), rd);
            apb_access(1'b1, `SEQ_REG_CTRL, 32'd2, rd);
            do begin
                probe_during_run();
                apb_access(1'b0, `SEQ_REG_STATE, 32'h0, rd);
            end while (rd != 32'(ST_SHUT));
            compare_all_regs();             // profiles, main_cnt back at 0
        end

        // shutdown mid-run keeps the counter, clear zeroes it
        apb_access(1'b1, `SEQ_REG_END_CNT, 32'd3, rd);
        apb_access(1'b1, `SEQ_REG_CTRL, 32'd2, rd);
        do
            apb_access(1'b0, `SEQ_REG_MAIN_CNT, 32'h0, rd);
        while (rd != 32'd2);
        apb_access(1'b1, `SEQ_REG_CTRL, 32'd1, rd);
        check_value("handshake", {reprog, init, start_exec}, 3'b000);
        compare_all_regs();
        apb_access(1'b1, `SEQ_REG_CTRL, 32'd0, rd);
        apb_access(1'b0, `SEQ_REG_MAIN_CNT, 32'h0, rd);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

// ==== sim/slave_dma_bfm.sv ====
`timescale 1ns/1ns

module slave_dma_bfm #(
    parameter logic [31:0] SEED = 32'h1
) (
    input  logic clk,
    input  logic reprog,
    input  logic init,
    input  logic start_exec,
    output logic reprog_accept,
    output logic init_done,
    output logic start_accept,
    output logic exec_done
);
    int   seed;
    logic owe_done;     // start accepted, exec_done still due

    // random wait of 0 to 3 cycles, then a one-cycle response pulse
    task automatic respond(input int which);
        int wait_cyc;
        wait_cyc = $unsigned($random(seed)) % 4;
        repeat (wait_cyc) begin
            @(posedge clk);
            #2;
        end
        case (which)
            0:       reprog_accept = 1'b1;
            1:       init_done     = 1'b1;
            2:       start_accept  = 1'b1;
            default: exec_done     = 1'b1;
        endcase
        @(posedge clk);     // sampled by the sequencer here
        #2;
        reprog_accept = 1'b0;
        init_done     = 1'b0;
        start_accept  = 1'b0;
        exec_done     = 1'b0;
    endtask

    initial begin
        seed          = SEED;
        owe_done      = 1'b0;
        reprog_accept = 1'b0;
        init_done     = 1'b0;
        start_accept  = 1'b0;
        exec_done     = 1'b0;
        @(posedge clk);
        #2;
        forever begin
            if (reprog) begin
                respond(0);
            end else if (init) begin
                respond(1);
            end else if (start_exec) begin
                respond(2);
                owe_done = 1'b1;        // slot now executing
            end else if (owe_done) begin
                respond(3);
                owe_done = 1'b0;
            end else begin
                @(posedge clk);         // idle, look again next cycle
                #2;
            end
        end
    end

endmodule

// ==== sources.f ====
+incdir+design
design/seq_pkg.sv
design/slot_pkg.sv
design/apb_reg_port.sv
design/slot_table.sv
design/seq_fsm.sv
design/seq_top.sv
sim/slave_dma_bfm.sv
sim/seq_tb.sv
